/* hw/mchan_params.svh */
// Widths and register indices; at most 16 transfers so the alloc bits fit above bit 16
`ifndef MCHAN_PARAMS_SVH
`define MCHAN_PARAMS_SVH

// ************************************************************
// Transfer IDs and 2D queue
// ************************************************************
`define MCHAN_NB_TRANSFERS     4
`define MCHAN_SID_WIDTH        ((`MCHAN_NB_TRANSFERS > 1) ? $clog2(`MCHAN_NB_TRANSFERS) : 1)
`define MCHAN_TWD_QUEUE_DEPTH  4
`define MCHAN_TWD_ADD_WIDTH    ((`MCHAN_TWD_QUEUE_DEPTH > 1) ? $clog2(`MCHAN_TWD_QUEUE_DEPTH) : 1)

// ************************************************************
// Command word fields
// ************************************************************
`define MCHAN_TCDM_ADD_WIDTH   12
`define MCHAN_EXT_ADD_WIDTH    29
`define MCHAN_LEN_WIDTH        15 // Word field is one bit wider
`define MCHAN_OPC_WIDTH        1
`define MCHAN_CMD_PAD_WIDTH    (32 - `MCHAN_LEN_WIDTH - 1 - `MCHAN_OPC_WIDTH - 5)
`define MCHAN_TWD_COUNT_WIDTH  16 // Low half of the 2D word
`define MCHAN_TWD_STRIDE_WIDTH 16 // High half

// Register map, index taken from address bits 3:2
`define MCHAN_REG_IDX_WIDTH    2
`define MCHAN_CMD_REG          2'd0
`define MCHAN_STATUS_REG       2'd1
`define MCHAN_ALLOC_STATUS_LSB 16 // Alloc bits in a status read

`endif

/* hw/mchan_pkg.sv */
// Shared types; field widths come from the params header, cmd word is 32 bits with length at bit 0
`include "mchan_params.svh"

package mchan_pkg;

   // ************************************************************
   // Control target
   // ************************************************************

   // Command word view, length in the low bits
   typedef struct packed {
      logic [`MCHAN_CMD_PAD_WIDTH-1:0] pad;
      logic                            ble;  // Broadcast lines enable
      logic                            ile;  // Interrupt lines enable
      logic                            ele;  // Event lines enable
      logic                            twd;  // 2D transfer
      logic                            inc;  // Incremental
      logic [`MCHAN_OPC_WIDTH-1:0]     opc;
      logic [`MCHAN_LEN_WIDTH:0]       len;  // Bytes, full size fits
   } cmd_word_t;

   // 2D word view
   typedef struct packed {
      logic [`MCHAN_TWD_STRIDE_WIDTH-1:0] stride;
      logic [`MCHAN_TWD_COUNT_WIDTH-1:0]  count;
   } twd_word_t;

   // Same write word, decoded per sequence step
   typedef union packed {
      cmd_word_t   cmd;
      twd_word_t   twd;
      logic [31:0] raw;
   } ctrl_wdata_u;

   typedef struct packed {
      logic                            req;
      logic                            rd;      // 1 is read
      logic [`MCHAN_REG_IDX_WIDTH-1:0] reg_idx;
      ctrl_wdata_u                     wdata;
   } ctrl_req_t;

   typedef struct packed {
      logic        gnt;
      logic        r_valid;
      logic [31:0] r_data;
   } ctrl_rsp_t;

   // ************************************************************
   // Downstream queues and arbiter
   // ************************************************************
   typedef struct packed {
      logic [`MCHAN_LEN_WIDTH-1:0]     len;  // Length minus one
      logic [`MCHAN_OPC_WIDTH-1:0]     opc;
      logic                            inc;
      logic                            twd;
      logic                            ele;
      logic                            ile;
      logic                            ble;
      logic [`MCHAN_SID_WIDTH-1:0]     sid;
      logic [`MCHAN_TWD_ADD_WIDTH-1:0] twd_add;
   } cmd_t;

   typedef struct packed {
      logic [`MCHAN_TWD_ADD_WIDTH-1:0]    add;
      logic [`MCHAN_TWD_COUNT_WIDTH-1:0]  count;   // Minus one
      logic [`MCHAN_TWD_STRIDE_WIDTH-1:0] stride;  // Minus one
      logic [`MCHAN_SID_WIDTH-1:0]        sid;
   } twd_queue_t;

   typedef struct packed {
      logic                        req;
      logic                        gnt;
      logic [`MCHAN_SID_WIDTH-1:0] sid;
   } arb_t;

endpackage

/* hw/mchan_ctrl_fsm.sv */
// Control target FSM; cmd writes only after a SID read, other requests in idle wait ungranted
`timescale 1ns/1ps
`include "mchan_params.svh"

module mchan_ctrl_fsm
(
   input  logic                               clk_i,
   input  logic                               rst_ni,
   // Control target
   input  mchan_pkg::ctrl_req_t               ctrl_req_i,
   output mchan_pkg::ctrl_rsp_t               ctrl_rsp_o,
   // Queue pushes, grants are not-full levels
   input  logic                               cmd_gnt_i,
   input  logic                               tcdm_gnt_i,
   input  logic                               ext_gnt_i,
   output logic                               cmd_req_o,
   output logic                               tcdm_req_o,
   output logic                               ext_req_o,
   output logic                               twd_queue_req_o,
   // SID buffer and 2D allocator
   output logic                               trans_alloc_req_o,
   input  logic                               trans_alloc_gnt_i,
   output logic                               twd_alloc_req_o,
   input  logic                               twd_alloc_gnt_i,
   output logic [`MCHAN_NB_TRANSFERS-1:0]     trans_alloc_clr_o,
   input  logic [`MCHAN_NB_TRANSFERS-1:0]     trans_status_i,
   input  logic [`MCHAN_NB_TRANSFERS-1:0]     trans_alloc_status_i,
   // Transfer context
   input  logic [`MCHAN_SID_WIDTH-1:0]        cur_sid_i,
   input  logic                               twd_pending_i,
   input  logic                               arb_hit_i,
   output logic                               sid_load_o,
   output logic                               twd_add_load_o,
   output logic                               twd_set_o,
   output logic                               twd_clr_o,
   output logic                               busy_o
);

   typedef enum logic [3:0]
   {
      IDLE,
      STAT_RSP,   // Status read data out
      SID_RSP,    // SID read data out, waiting for cmd word
      CMD_WAIT,
      TCDM_WAIT,
      EXT_WAIT,
      TWD_WAIT,   // 2D word, slot already reserved
      BUSY_ARB,   // Waiting for the arbiter
      BUSY_DONE   // Waiting for completion bit
   } state_e;

   state_e state_q, state_d;
   state_e busy_next;      // Busy entry after the last word
   logic   gnt;
   logic   r_valid_q;
   logic   wr_cmd;         // Legal sequence word
   logic   seq_abort;      // Anything else during a sequence
   logic   twd_cmd;        // 2D bit of the cmd word view

   assign wr_cmd    = ctrl_req_i.req && !ctrl_req_i.rd && (ctrl_req_i.reg_idx == `MCHAN_CMD_REG);
   assign seq_abort = ctrl_req_i.req && !wr_cmd;
   assign twd_cmd   = ctrl_req_i.wdata.cmd.twd;
   assign busy_next = arb_hit_i ? BUSY_DONE : BUSY_ARB; // Hit may come with the last word
   assign busy_o    = (state_q != IDLE);

   // ************************************************************
   // Next state and strobes
   // ************************************************************
   always_comb
   begin
      state_d           = state_q;
      gnt               = 1'b0;
      cmd_req_o         = 1'b0;
      tcdm_req_o        = 1'b0;
      ext_req_o         = 1'b0;
      twd_queue_req_o   = 1'b0;
      trans_alloc_req_o = 1'b0;
      twd_alloc_req_o   = 1'b0;
      trans_alloc_clr_o = '0;
      sid_load_o        = 1'b0;
      twd_add_load_o    = 1'b0;
      twd_set_o         = 1'b0;
      twd_clr_o         = 1'b0;

      case (state_q)
         IDLE:
         begin
            if (ctrl_req_i.req && ctrl_req_i.reg_idx == `MCHAN_STATUS_REG)
            begin
               gnt = 1'b1;                       // Status access never stalls
               if (ctrl_req_i.rd)
                  state_d = STAT_RSP;
               else                              // Clear mask for one cycle
                  trans_alloc_clr_o = ctrl_req_i.wdata.raw[`MCHAN_NB_TRANSFERS-1:0];
            end
            else if (ctrl_req_i.req && ctrl_req_i.rd && ctrl_req_i.reg_idx == `MCHAN_CMD_REG)
            begin
               trans_alloc_req_o = 1'b1;         // SID allocation
               if (trans_alloc_gnt_i)
               begin
                  gnt        = 1'b1;
                  sid_load_o = 1'b1;
                  state_d    = SID_RSP;
               end
            end
         end

         STAT_RSP:
            state_d = IDLE;

         SID_RSP, CMD_WAIT:
         begin
            state_d = CMD_WAIT;
            if (wr_cmd && cmd_gnt_i)
            begin
               // Reserve the 2D slot together with the cmd push
               twd_alloc_req_o = twd_cmd;
               if (!twd_cmd || twd_alloc_gnt_i)
               begin
                  gnt            = 1'b1;
                  cmd_req_o      = 1'b1;
                  twd_add_load_o = twd_cmd;
                  twd_set_o      = twd_cmd;
                  state_d        = TCDM_WAIT;
               end
            end
            else if (seq_abort)
            begin
               twd_clr_o = 1'b1;
               state_d   = IDLE;
            end
         end

         TCDM_WAIT:
         begin
            if (wr_cmd && tcdm_gnt_i)
            begin
               gnt        = 1'b1;
               tcdm_req_o = 1'b1;
               state_d    = EXT_WAIT;
            end
            else if (seq_abort)
            begin
               twd_clr_o = 1'b1;                 // Drop a pending 2D flag
               state_d   = IDLE;
            end
         end

         EXT_WAIT:
         begin
            if (wr_cmd && ext_gnt_i)
            begin
               gnt       = 1'b1;
               ext_req_o = 1'b1;
               state_d   = twd_pending_i ? TWD_WAIT : busy_next;
            end
            else if (seq_abort)
            begin
               twd_clr_o = 1'b1;
               state_d   = IDLE;
            end
         end

         TWD_WAIT:
         begin
            if (wr_cmd)                         // No downstream grant needed
            begin
               gnt             = 1'b1;
               twd_queue_req_o = 1'b1;
               twd_clr_o       = 1'b1;
               state_d         = busy_next;
            end
            else if (seq_abort)
            begin
               twd_clr_o = 1'b1;
               state_d   = IDLE;
            end
         end

         BUSY_ARB:
            if (arb_hit_i)
               state_d = BUSY_DONE;

         BUSY_DONE:
            if (trans_status_i[cur_sid_i])
               state_d = IDLE;

         default:
            state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q   <= IDLE;
         r_valid_q <= 1'b0;
      end
      else
      begin
         state_q   <= state_d;
         r_valid_q <= gnt;   // One r_valid per grant
      end
   end

   // ************************************************************
   // Read response
   // ************************************************************
   always_comb
   begin
      ctrl_rsp_o.gnt     = gnt;
      ctrl_rsp_o.r_valid = r_valid_q;
      ctrl_rsp_o.r_data  = '0;   // Writes return zero
      if (state_q == STAT_RSP)
      begin
         ctrl_rsp_o.r_data[`MCHAN_NB_TRANSFERS-1:0] = trans_status_i;
         ctrl_rsp_o.r_data[`MCHAN_ALLOC_STATUS_LSB +: `MCHAN_NB_TRANSFERS] = trans_alloc_status_i;
      end
      else if (state_q == SID_RSP)
         ctrl_rsp_o.r_data[`MCHAN_SID_WIDTH-1:0] = cur_sid_i; // Loaded on the grant edge
   end

endmodule

/* hw/mchan_xfer_ctx.sv */
// Transfer context; fields are decoded live from the write word, valid only with their push
`timescale 1ns/1ps
`include "mchan_params.svh"

module mchan_xfer_ctx
(
   input  logic                                clk_i,
   input  logic                                rst_ni,
   input  mchan_pkg::ctrl_wdata_u              wdata_i,
   input  logic [`MCHAN_SID_WIDTH-1:0]         trans_alloc_ret_i,
   input  logic [`MCHAN_TWD_ADD_WIDTH-1:0]     twd_alloc_add_i,
   input  mchan_pkg::arb_t                     arb_i,
   // Load strobes from the FSM
   input  logic                                sid_load_i,
   input  logic                                twd_add_load_i,
   input  logic                                twd_set_i,
   input  logic                                twd_clr_i,
   // Queue payloads
   output mchan_pkg::cmd_t                     cmd_o,
   output logic [`MCHAN_TCDM_ADD_WIDTH-1:0]    tcdm_add_o,
   output logic [`MCHAN_EXT_ADD_WIDTH-1:0]     ext_add_o,
   output mchan_pkg::twd_queue_t               twd_queue_o,
   output logic                                twd_trans_o,
   output logic [`MCHAN_SID_WIDTH-1:0]         cur_sid_o,
   output logic                                arb_hit_o
);

   logic [`MCHAN_SID_WIDTH-1:0]     sid_q;
   logic [`MCHAN_TWD_ADD_WIDTH-1:0] twd_add_q;     // Reserved 2D slot
   logic                            twd_pending_q; // Cmd pushed, 2D word not yet
   logic [`MCHAN_LEN_WIDTH:0]       len_m1;

   // ************************************************************
   // Context registers
   // ************************************************************
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         sid_q         <= '0;
         twd_pending_q <= 1'b0;
      end
      else
      begin
         if (sid_load_i)
            sid_q <= trans_alloc_ret_i;   // Same cycle grant from SID buffer
         if (twd_set_i)
            twd_pending_q <= 1'b1;
         else if (twd_clr_i)
            twd_pending_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (twd_add_load_i)
         twd_add_q <= twd_alloc_add_i;
   end

   // ************************************************************
   // Field unpacking
   // ************************************************************
   assign len_m1 = wdata_i.cmd.len - (`MCHAN_LEN_WIDTH+1)'(1);   // Full size wraps to all ones

   always_comb
   begin
      cmd_o.len     = len_m1[`MCHAN_LEN_WIDTH-1:0];
      cmd_o.opc     = wdata_i.cmd.opc;
      cmd_o.inc     = wdata_i.cmd.inc;
      cmd_o.twd     = wdata_i.cmd.twd;
      cmd_o.ele     = wdata_i.cmd.ele;
      cmd_o.ile     = wdata_i.cmd.ile;
      cmd_o.ble     = wdata_i.cmd.ble;
      cmd_o.sid     = sid_q;
      cmd_o.twd_add = twd_alloc_add_i;       // Slot granted in the push cycle

      twd_queue_o.add    = twd_add_q;
      twd_queue_o.count  = wdata_i.twd.count - (`MCHAN_TWD_COUNT_WIDTH)'(1);
      twd_queue_o.stride = wdata_i.twd.stride - (`MCHAN_TWD_STRIDE_WIDTH)'(1);
      twd_queue_o.sid    = sid_q;
   end

   assign tcdm_add_o  = wdata_i.raw[`MCHAN_TCDM_ADD_WIDTH-1:0];
   assign ext_add_o   = wdata_i.raw[`MCHAN_EXT_ADD_WIDTH-1:0];
   assign twd_trans_o = twd_pending_q;
   assign cur_sid_o   = sid_q;

   // Arbiter granted our SID this cycle
   assign arb_hit_o = arb_i.req && arb_i.gnt && (arb_i.sid == sid_q);

endmodule

/* hw/mchan_cmd_front.sv */
// DMA command front end top; downstream FIFOs, SID buffer and arbiter are external
`timescale 1ns/1ps
`include "mchan_params.svh"

module mchan_cmd_front
(
   input  logic                                clk_i,
   input  logic                                rst_ni,
   // Control target
   input  mchan_pkg::ctrl_req_t                ctrl_req_i,
   output mchan_pkg::ctrl_rsp_t                ctrl_rsp_o,
   // Cmd, TCDM and ext queues
   input  logic                                cmd_gnt_i,
   output logic                                cmd_req_o,
   output mchan_pkg::cmd_t                     cmd_o,
   input  logic                                tcdm_gnt_i,
   output logic                                tcdm_req_o,
   output logic [`MCHAN_TCDM_ADD_WIDTH-1:0]    tcdm_add_o,
   input  logic                                ext_gnt_i,
   output logic                                ext_req_o,
   output logic [`MCHAN_EXT_ADD_WIDTH-1:0]     ext_add_o,
   // 2D allocator and queue
   output logic                                twd_alloc_req_o,
   input  logic                                twd_alloc_gnt_i,
   input  logic [`MCHAN_TWD_ADD_WIDTH-1:0]     twd_alloc_add_i,
   output logic                                twd_queue_req_o,
   output mchan_pkg::twd_queue_t               twd_queue_o,
   output logic                                twd_trans_o,
   // SID buffer
   output logic                                trans_alloc_req_o,
   input  logic                                trans_alloc_gnt_i,
   input  logic [`MCHAN_SID_WIDTH-1:0]         trans_alloc_ret_i,
   output logic [`MCHAN_NB_TRANSFERS-1:0]      trans_alloc_clr_o,
   input  logic [`MCHAN_NB_TRANSFERS-1:0]      trans_alloc_status_i,
   input  logic [`MCHAN_NB_TRANSFERS-1:0]      trans_status_i,
   // Synchronisation arbiter
   input  mchan_pkg::arb_t                     arb_i,
   output logic                                busy_o
);

   logic [`MCHAN_SID_WIDTH-1:0] cur_sid;
   logic                        arb_hit;
   logic                        sid_load;
   logic                        twd_add_load;
   logic                        twd_set;
   logic                        twd_clr;

   mchan_ctrl_fsm u_fsm
   (
      .clk_i                (clk_i),
      .rst_ni               (rst_ni),
      .ctrl_req_i           (ctrl_req_i),
      .ctrl_rsp_o           (ctrl_rsp_o),
      .cmd_gnt_i            (cmd_gnt_i),
      .tcdm_gnt_i           (tcdm_gnt_i),
      .ext_gnt_i            (ext_gnt_i),
      .cmd_req_o            (cmd_req_o),
      .tcdm_req_o           (tcdm_req_o),
      .ext_req_o            (ext_req_o),
      .twd_queue_req_o      (twd_queue_req_o),
      .trans_alloc_req_o    (trans_alloc_req_o),
      .trans_alloc_gnt_i    (trans_alloc_gnt_i),
      .twd_alloc_req_o      (twd_alloc_req_o),
      .twd_alloc_gnt_i      (twd_alloc_gnt_i),
      .trans_alloc_clr_o    (trans_alloc_clr_o),
      .trans_status_i       (trans_status_i),
      .trans_alloc_status_i (trans_alloc_status_i),
      .cur_sid_i            (cur_sid),
      .twd_pending_i        (twd_trans_o),     // 2D flag also drives the output
      .arb_hit_i            (arb_hit),
      .sid_load_o           (sid_load),
      .twd_add_load_o       (twd_add_load),
      .twd_set_o            (twd_set),
      .twd_clr_o            (twd_clr),
      .busy_o               (busy_o)
   );

   mchan_xfer_ctx u_ctx
   (
      .clk_i             (clk_i),
      .rst_ni            (rst_ni),
      .wdata_i           (ctrl_req_i.wdata),
      .trans_alloc_ret_i (trans_alloc_ret_i),
      .twd_alloc_add_i   (twd_alloc_add_i),
      .arb_i             (arb_i),
      .sid_load_i        (sid_load),
      .twd_add_load_i    (twd_add_load),
      .twd_set_i         (twd_set),
      .twd_clr_i         (twd_clr),
      .cmd_o             (cmd_o),
      .tcdm_add_o        (tcdm_add_o),
      .ext_add_o         (ext_add_o),
      .twd_queue_o       (twd_queue_o),
      .twd_trans_o       (twd_trans_o),
      .cur_sid_o         (cur_sid),
      .arb_hit_o         (arb_hit)
   );

endmodule

/* bench/mchan_tb_vectors.svh */
// Table rows for the command front testbench; SIDs and slots must fit 2 bits, status fields 4 bits
`ifndef MCHAN_TB_VECTORS_SVH
`define MCHAN_TB_VECTORS_SVH

// Columns: name, kind, w0 cmd or clear, w1 tcdm, w2 ext, w3 2D word,
//          model SID, model 2D slot, trans status, alloc status, expected read data
task automatic load_table();
   // ************************************************************
   // Plain reads and writes
   // ************************************************************
   add_row("status_read", OP_STAT, 32'h0, 32'h0, 32'h0, 32'h0,
           2'd0, 2'd0, 4'b1010, 4'b0110, 32'h0006_000a);
   add_row("clear", OP_CLR, 32'hffff_0005, 32'h0, 32'h0, 32'h0,
           2'd0, 2'd0, 4'b0000, 4'b0000, 32'h0);
   // SID read then a status read that aborts the sequence
   add_row("sid_abort", OP_SID, 32'h0, 32'h0, 32'h0, 32'h0,
           2'd3, 2'd0, 4'b0001, 4'b1000, 32'h0008_0001);

   // ************************************************************
   // Command sequences
   // ************************************************************
   // len 0x40, opc, inc, ele
   add_row("seq_1d_a", OP_1D, 32'h000b_0040, 32'hffff_fabc, 32'he123_4568, 32'h0,
           2'd2, 2'd1, 4'b0000, 4'b0000, 32'h0);
   // len 1, ile and ble
   add_row("seq_1d_b", OP_1D, 32'h0030_0001, 32'h0000_0010, 32'h1fff_fff0, 32'h0,
           2'd0, 2'd2, 4'b0000, 4'b0000, 32'h0);
   // Full size length wraps, inc, twd, ble
   add_row("seq_2d_a", OP_2D, 32'h0026_0000, 32'h0000_0123, 32'h0000_4000, 32'h0100_0008,
           2'd1, 2'd3, 4'b0000, 4'b0000, 32'h0);
   add_row("seq_2d_b", OP_2D, 32'h0005_0200, 32'h0000_0ffc, 32'h0abc_def0, 32'h0001_0001,
           2'd3, 2'd0, 4'b0000, 4'b0000, 32'h0);
   add_row("status_after", OP_STAT, 32'h0, 32'h0, 32'h0, 32'h0,
           2'd0, 2'd0, 4'b0101, 4'b1111, 32'h000f_0005);
endtask

`endif

/* bench/mchan_cmd_front_tb.sv */
// Testbench for the command front; models queues, SID buffer, 2D allocator and arbiter
`timescale 1ns/1ps
`include "mchan_params.svh"

module mchan_cmd_front_tb;
   import mchan_pkg::*;

   localparam int OP_SID = 0, OP_1D = 1, OP_2D = 2, OP_STAT = 3, OP_CLR = 4;
   localparam int SEL_NONE = 0, SEL_ALLOC = 1, SEL_CMD = 2, SEL_TCDM = 3, SEL_EXT = 4;

   logic clk_i, rst_ni;
   ctrl_req_t ctrl_req_i;
   ctrl_rsp_t ctrl_rsp_o;
   logic cmd_gnt_i, cmd_req_o, tcdm_gnt_i, tcdm_req_o, ext_gnt_i, ext_req_o;
   cmd_t cmd_o;
   logic [`MCHAN_TCDM_ADD_WIDTH-1:0] tcdm_add_o;
   logic [`MCHAN_EXT_ADD_WIDTH-1:0]  ext_add_o;
   logic twd_alloc_req_o, twd_alloc_gnt_i, twd_queue_req_o, twd_trans_o;
   logic [`MCHAN_TWD_ADD_WIDTH-1:0] twd_alloc_add_i;
   twd_queue_t twd_queue_o;
   logic trans_alloc_req_o, trans_alloc_gnt_i, busy_o;
   logic [`MCHAN_SID_WIDTH-1:0] trans_alloc_ret_i;
   logic [`MCHAN_NB_TRANSFERS-1:0] trans_alloc_clr_o, trans_alloc_status_i, trans_status_i;
   arb_t arb_i;

   // Table columns
   string names[$];
   int kinds[$];
   logic [31:0] w0_q[$], w1_q[$], w2_q[$], w3_q[$], exp_r_q[$];
   logic [1:0] sid_q[$], slot_q[$];
   logic [3:0] stat_q[$], alloc_q[$];

   logic [31:0] lfsr_q = 32'hd8f1;
   int cycle_cnt = 0;
   int cycle_limit = 10;
   int cmd_cnt, tcdm_cnt, ext_cnt, twdq_cnt;   // Pushes per row

   mchan_cmd_front uut (.*);

   task automatic add_row(input string name, input int kind, input logic [31:0] w0,
                          input logic [31:0] w1, input logic [31:0] w2, input logic [31:0] w3,
                          input logic [1:0] sid, input logic [1:0] slot, input logic [3:0] stat,
                          input logic [3:0] alloc, input logic [31:0] exp_r);
      names.push_back(name);
      kinds.push_back(kind);
      w0_q.push_back(w0);
      w1_q.push_back(w1);
      w2_q.push_back(w2);
      w3_q.push_back(w3);
      sid_q.push_back(sid);
      slot_q.push_back(slot);
      stat_q.push_back(stat);
      alloc_q.push_back(alloc);
      exp_r_q.push_back(exp_r);
   endtask

   `include "mchan_tb_vectors.svh"

   initial
   begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   // Cycle limit from table length
   always @(posedge clk_i)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit)
      begin
         $display("*** FAILED ***");
         $fatal(1, "run exceeded its cycle limit of %0d, DUT stopped responding", cycle_limit);
      end
   end

   always @(negedge clk_i)
   begin
      if (cmd_req_o) cmd_cnt++;
      if (tcdm_req_o) tcdm_cnt++;
      if (ext_req_o) ext_cnt++;
      if (twd_queue_req_o) twdq_cnt++;
   end

   // Galois LFSR, one step per bit
   function automatic int lfsr_bits(input int nbits);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < nbits; k++)
      begin
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
         v = {v[30:0], lfsr_q[0]};
      end
      return int'(v);
   endfunction

   task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act)
      begin
         $display("error %s: expected %h, actual %h", name, exp, act);
         $display("*** FAILED ***");
         $fatal(1, "value mismatch");
      end
   endtask

   // Expected cmd queue entry from the word's bit layout
   function automatic cmd_t expect_cmd(input logic [31:0] w, input logic [1:0] sid,
                                       input logic [1:0] slot);
      cmd_t c;
      logic [15:0] len_m1;
      len_m1 = w[15:0] - 16'd1;
      c.len = len_m1[14:0];
      c.opc = w[16];
      c.inc = w[17];
      c.twd = w[18];
      c.ele = w[19];
      c.ile = w[20];
      c.ble = w[21];
      c.sid = sid;
      c.twd_add = slot;
      return c;
   endfunction

   function automatic twd_queue_t expect_twd(input logic [31:0] w, input logic [1:0] sid,
                                             input logic [1:0] slot);
      twd_queue_t t;
      t.add    = slot;
      t.count  = w[15:0] - 16'd1;
      t.stride = w[31:16] - 16'd1;
      t.sid    = sid;
      return t;
   endfunction

   task automatic set_grant(input int sel, input logic v);
      case (sel)
         SEL_ALLOC: trans_alloc_gnt_i <= v;
         SEL_CMD:   cmd_gnt_i <= v;
         SEL_TCDM:  tcdm_gnt_i <= v;
         SEL_EXT:   ext_gnt_i <= v;
         default:   ;
      endcase
   endtask

   // Level of the downstream grant a step waits for
   function automatic logic grant_level(input int sel);
      case (sel)
         SEL_ALLOC: return trans_alloc_gnt_i;
         SEL_CMD:   return cmd_gnt_i;
         SEL_TCDM:  return tcdm_gnt_i;
         SEL_EXT:   return ext_gnt_i;
         default:   return 1'b1;
      endcase
   endfunction

   // Drive one access; returns at the falling edge of its grant cycle
   task automatic access(input string name, input int sel, input logic rd,
                         input logic [1:0] idx, input logic [31:0] data);
      int n;
      n = lfsr_bits(2);                        // Grant low for 0..3 cycles
      @(posedge clk_i);
      ctrl_req_i <= {1'b1, rd, idx, data};
      set_grant(sel, n == 0);
      while (1)
      begin
         @(negedge clk_i);
         if (ctrl_rsp_o.gnt)
         begin
            check({name, "/gnt_level"}, 64'(1), 64'(grant_level(sel)));
            break;
         end
         check({name, "/hold"}, 64'(0),
               64'({cmd_req_o, tcdm_req_o, ext_req_o, twd_queue_req_o}));
         @(posedge clk_i);
         if (n > 0) n--;
         if (n == 0) set_grant(sel, 1'b1);
      end
   endtask

   // Drop the request, check the response in the next cycle
   task automatic finish(input string name, input logic [31:0] exp_r);
      @(posedge clk_i);
      ctrl_req_i.req <= 1'b0;
      @(negedge clk_i);
      check({name, "/r_valid"}, 64'(1), 64'(ctrl_rsp_o.r_valid));
      check({name, "/r_data"}, 64'(exp_r), 64'(ctrl_rsp_o.r_data));
   endtask

   task automatic busy_wait(input string name, input int cycles);
      repeat (cycles)
      begin
         @(negedge clk_i);
         check({name, "/busy"}, 64'(1), 64'(busy_o));
      end
   endtask

   task automatic run_seq(input int i);
      string nm;
      logic twd;
      nm = names[i];
      twd = (kinds[i] == OP_2D);
      access(nm, SEL_ALLOC, 1'b1, `MCHAN_CMD_REG, 32'h0);
      check({nm, "/alloc_req"}, 64'(1), 64'(trans_alloc_req_o));
      finish(nm, 32'(sid_q[i]));
      @(posedge clk_i);
      trans_alloc_ret_i <= ~sid_q[i];          // SID buffer moves on, stored SID must stay
      // Command word
      access(nm, SEL_CMD, 1'b0, `MCHAN_CMD_REG, w0_q[i]);
      check({nm, "/cmd_req"}, 64'(1), 64'(cmd_req_o));
      check({nm, "/cmd"}, 64'(expect_cmd(w0_q[i], sid_q[i], slot_q[i])), 64'(cmd_o));
      check({nm, "/twd_alloc_req"}, 64'(twd), 64'(twd_alloc_req_o));
      finish(nm, 32'h0);
      check({nm, "/twd_trans"}, 64'(twd), 64'(twd_trans_o));
      @(posedge clk_i);
      twd_alloc_add_i <= ~slot_q[i];           // Allocator moves on, stored slot must stay
      // TCDM then ext address
      access(nm, SEL_TCDM, 1'b0, `MCHAN_CMD_REG, w1_q[i]);
      check({nm, "/tcdm_req"}, 64'(1), 64'(tcdm_req_o));
      check({nm, "/tcdm_add"}, 64'(w1_q[i][11:0]), 64'(tcdm_add_o));
      finish(nm, 32'h0);
      access(nm, SEL_EXT, 1'b0, `MCHAN_CMD_REG, w2_q[i]);
      check({nm, "/ext_req"}, 64'(1), 64'(ext_req_o));
      check({nm, "/ext_add"}, 64'(w2_q[i][28:0]), 64'(ext_add_o));
      check({nm, "/twd_trans_ext"}, 64'(twd), 64'(twd_trans_o));
      finish(nm, 32'h0);
      if (twd)
      begin
         access(nm, SEL_NONE, 1'b0, `MCHAN_CMD_REG, w3_q[i]);
         check({nm, "/twdq_req"}, 64'(1), 64'(twd_queue_req_o));
         check({nm, "/twdq"}, 64'(expect_twd(w3_q[i], sid_q[i], slot_q[i])),
               64'(twd_queue_o));
         finish(nm, 32'h0);
         check({nm, "/twd_trans_end"}, 64'(0), 64'(twd_trans_o));
      end
      check({nm, "/cmd_cnt"}, 64'(1), 64'(cmd_cnt));
      check({nm, "/tcdm_cnt"}, 64'(1), 64'(tcdm_cnt));
      check({nm, "/ext_cnt"}, 64'(1), 64'(ext_cnt));
      check({nm, "/twdq_cnt"}, 64'(twd), 64'(twdq_cnt));

      // ************************************************************
      // Busy until arbiter grant, then until completion
      // ************************************************************
      busy_wait(nm, lfsr_bits(3) + 1);
      @(posedge clk_i);
      arb_i <= {1'b1, 1'b1, sid_q[i]};
      @(posedge clk_i);
      arb_i <= '0;
      busy_wait(nm, lfsr_bits(3) + 1);
      @(posedge clk_i);
      trans_status_i <= 4'(1) << sid_q[i];
      busy_wait(nm, 1);
      @(negedge clk_i);
      check({nm, "/busy_end"}, 64'(0), 64'(busy_o));
   endtask

   initial
   begin
      ctrl_req_i <= '0;
      cmd_gnt_i <= 1'b1;
      tcdm_gnt_i <= 1'b1;
      ext_gnt_i <= 1'b1;
      trans_alloc_gnt_i <= 1'b1;
      twd_alloc_gnt_i <= 1'b1;
      twd_alloc_add_i <= '0;
      trans_alloc_ret_i <= '0;
      trans_alloc_status_i <= '0;
      trans_status_i <= '0;
      arb_i <= '0;
      rst_ni <= 1'b0;
      load_table();
      cycle_limit = 200 * names.size() + 10;
      repeat (10) @(posedge clk_i);
      rst_ni <= 1'b1;

      for (int i = 0; i < names.size(); i++)
      begin
         @(posedge clk_i);
         cmd_cnt = 0;
         tcdm_cnt = 0;
         ext_cnt = 0;
         twdq_cnt = 0;
         trans_alloc_ret_i <= sid_q[i];
         twd_alloc_add_i <= slot_q[i];
         trans_status_i <= (kinds[i] == OP_STAT || kinds[i] == OP_SID) ? stat_q[i] : 4'h0;
         trans_alloc_status_i <= alloc_q[i];
         @(negedge clk_i);
         check({names[i], "/idle_busy"}, 64'(0), 64'(busy_o));
         case (kinds[i])
            OP_SID:
            begin
               access(names[i], SEL_ALLOC, 1'b1, `MCHAN_CMD_REG, 32'h0);
               finish(names[i], 32'(sid_q[i]));
               check({names[i], "/busy_seq"}, 64'(1), 64'(busy_o));
               // Status read aborts the sequence, then gets its grant
               access(names[i], SEL_NONE, 1'b1, `MCHAN_STATUS_REG, 32'h0);
               finish(names[i], exp_r_q[i]);
            end
            OP_STAT:
            begin
               access(names[i], SEL_NONE, 1'b1, `MCHAN_STATUS_REG, 32'h0);
               finish(names[i], exp_r_q[i]);
            end
            OP_CLR:
            begin
               access(names[i], SEL_NONE, 1'b0, `MCHAN_STATUS_REG, w0_q[i]);
               check({names[i], "/clr"}, 64'(w0_q[i][3:0]), 64'(trans_alloc_clr_o));
               finish(names[i], 32'h0);
               check({names[i], "/clr_end"}, 64'(0), 64'(trans_alloc_clr_o));
            end
            default:
               run_seq(i);
         endcase
      end
      repeat (2) @(posedge clk_i);
      $display("*** PASSED ***");
      $finish;
   end

endmodule

/* filelist.f */
+incdir+hw
+incdir+bench
hw/mchan_pkg.sv
hw/mchan_ctrl_fsm.sv
hw/mchan_xfer_ctx.sv
hw/mchan_cmd_front.sv
bench/mchan_cmd_front_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       := mchan_cmd_front_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard hw/*.sv hw/*.svh bench/*.sv bench/*.svh)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status is nonzero when the testbench hits $fatal
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
